//--- eth_mac_rx.f
eth_rx_pkg.sv
eth_crc32.sv
gmii_rx_framer.sv
mcf_rx_parser.sv
lfc_rx_pause.sv
rx_cfg_regs.sv
eth_mac_rx.sv
tb_clock_gen.sv
tb_eth_mac_rx.sv

//--- Makefile
SIM = obj_dir/Vtb_eth_mac_rx

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_eth_mac_rx -f eth_mac_rx.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- eth_mac_rx_patterns.txt
// steps in hex: 00 end | 01 addr data_hi data_lo | 03 paused_hi paused_lo
// 02 err_idx fcs_xor exp_len exp_flags hdr_len hdr_bytes pad_len (fcs appended by testbench)
// exp_flags: bit0 user, 1 bad_frame, 2 bad_fcs, 3 mcf, 4 lfc_pkt, 5 lfc_req after frame
// good frame, then bad fcs, gmii error on byte 20, and a 40 byte runt
02 ff 00 3c 00 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 2e
02 ff 01 3c 05 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 2e
02 14 00 3c 03 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 2e
02 ff 00 24 03 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 16
// pause frame with lfc disabled, then with another destination
02 ff 00 3c 08 12 01 80 c2 00 00 01 00 11 22 33 44 55 88 08 00 01 00 03 2a
01 03 00 02
02 ff 00 3c 00 12 01 80 c2 00 00 01 00 11 22 33 44 55 88 08 00 01 00 03 2a
01 03 00 01
// lfc enabled: two quanta, wait them out, then five quanta cleared by zero
01 00 00 03
02 ff 00 3c 38 12 01 80 c2 00 00 01 00 11 22 33 44 55 88 08 00 01 00 02 2a
03 00 02
02 ff 00 3c 38 12 01 80 c2 00 00 01 00 11 22 33 44 55 88 08 00 01 00 05 2a
02 ff 00 3c 18 12 01 80 c2 00 00 01 00 11 22 33 44 55 88 08 00 01 00 00 2a
// receive disabled, then enabled again
01 00 00 02
02 ff 00 00 00 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 2e
01 00 00 03
02 ff 00 3c 00 0e 00 0a 35 01 02 03 00 11 22 33 44 55 08 00 2e
00

//--- tb_eth_mac_rx.sv
// ethernet receive mac testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_rx;
    import eth_rx_pkg::*;

    localparam int MEM_DEPTH = 512;
    localparam int BUF_DEPTH = 2048;
    localparam int MAX_FRAME = 520;
    localparam int NUM_EVT   = 7;

    logic      rx_clk;
    logic      rx_rst;
    byte_t     gmii_rxd;
    logic      gmii_rx_dv;
    logic      gmii_rx_er;
    logic      rx_lfc_ack;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    byte_t     rx_data;
    logic      rx_valid;
    logic      rx_last;
    logic      rx_user;
    logic      rx_start_packet;
    logic      rx_error_bad_frame;
    logic      rx_error_bad_fcs;
    logic      stat_rx_mcf;
    logic      stat_rx_lfc_pkt;
    logic      stat_rx_lfc_paused;
    logic      rx_lfc_req;

    byte_t       pat_mem [MEM_DEPTH];
    byte_t       tx_buf [MAX_FRAME];    // frame after the sfd with its fcs.
    byte_t       rx_bytes [BUF_DEPTH];  // every byte seen on rx_data.
    int          rx_byte_count = 0;
    int          last_pos      = 0;
    int          start_pos     = 0;
    int          evt_count [NUM_EVT];
    logic [6:0]  evt_now;
    logic [31:0] rng_state     = 32'hd153;
    int          error_count   = 0;
    int          timeout_count = 0;
    string       evt_name [NUM_EVT] = '{"rx_start_packet", "rx_last", "rx_user",
        "rx_error_bad_frame", "rx_error_bad_fcs", "stat_rx_mcf", "stat_rx_lfc_pkt"};

    tb_clock_gen tb_clock_gen_inst (
        .rx_clk(rx_clk),
        .rx_rst(rx_rst)
    );

    eth_mac_rx #(
        .MIN_FRAME_LEN(64)
    ) eth_mac_rx_inst (.*);

    // pulses counted by the monitor in the order of evt_name.
    assign evt_now = {stat_rx_lfc_pkt, stat_rx_mcf, rx_error_bad_fcs, rx_error_bad_frame,
                      rx_last && rx_user, rx_last, rx_start_packet};

    // outputs only move on the rising edge, so sample on the falling one.
    always @(negedge rx_clk) begin
        if (rx_valid) begin
            rx_bytes[rx_byte_count % BUF_DEPTH] <= rx_data;
            rx_byte_count <= rx_byte_count + 1;
            if (rx_last) begin
                last_pos <= rx_byte_count + 1;  // this byte included.
            end
        end
        if (rx_start_packet) begin
            start_pos <= rx_byte_count;
        end
        for (int e = 0; e < NUM_EVT; e++) begin
            if (evt_now[e]) begin
                evt_count[e] <= evt_count[e] + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 802.3 fcs with an msb first register and data bits taken lsb first.
    function automatic logic [31:0] fcs_of(input int n);
        logic [31:0] c;
        logic        fb;
        int          i;
        int          b;
        c = 32'hffffffff;
        for (i = 0; i < n; i++) begin
            for (b = 0; b < 8; b++) begin
                fb = c[31] ^ tx_buf[i][b];
                c  = {c[30:0], 1'b0};
                if (fb) begin
                    c = c ^ 32'h04c11db7;
                end
            end
        end
        return ~c;
    endfunction

    // x^31 goes out first in bit 0 of the first fcs byte.
    function automatic byte_t fcs_wire_byte(input logic [31:0] fcs, input int k);
        byte_t v;
        int    j;
        for (j = 0; j < 8; j++) begin
            v[j] = fcs[31 - 8 * k - j];
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        repeat (12 + rng_state[3:0]) @(negedge rx_clk);
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        @(negedge rx_clk);
        while (rx_rst && waited < 20) begin
            @(negedge rx_clk);
            waited++;
        end
        if (rx_rst) begin
            $display("timeout at %0t ns: reset was never released", $time);
            timeout_count++;
        end
    endtask

    task automatic write_config(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge rx_clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge rx_clk);
        cfg_wr    = 1'b0;
    endtask

    task automatic drive_frame(input int len, input int err_idx);
        int i;
        for (i = 0; i < 7; i++) begin
            @(negedge rx_clk);
            gmii_rx_dv = 1'b1;
            gmii_rxd   = ETH_PREAMBLE;
        end
        @(negedge rx_clk);
        gmii_rxd = ETH_SFD;
        for (i = 0; i < len; i++) begin
            @(negedge rx_clk);
            gmii_rxd   = tx_buf[i];
            gmii_rx_er = (i == err_idx);
        end
        @(negedge rx_clk);
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        gmii_rxd   = '0;
    endtask

    task automatic run_frame_step(inout int pc);
        int         err_idx;
        int         fcs_xor;
        int         exp_len;
        int         exp_flags;
        int         hdr_len;
        int         n;
        int         i;
        int         waited;
        int         byte_base;
        int         got_len;
        int         base [NUM_EVT];
        logic [6:0] exp_evt;
        logic [31:0] fcs;
        err_idx   = pat_mem[pc + 1];
        fcs_xor   = pat_mem[pc + 2];
        exp_len   = pat_mem[pc + 3];
        exp_flags = pat_mem[pc + 4];
        hdr_len   = pat_mem[pc + 5];
        for (i = 0; i < hdr_len; i++) begin
            tx_buf[i] = pat_mem[pc + 6 + i];
        end
        n  = hdr_len + pat_mem[pc + 6 + hdr_len];
        pc = pc + 7 + hdr_len;
        for (i = hdr_len; i < n; i++) begin
            rng_state = xorshift32(rng_state);
            tx_buf[i] = rng_state[7:0];  // random padding.
        end
        fcs = fcs_of(n);
        for (i = 0; i < FCS_LEN; i++) begin
            tx_buf[n + i] = fcs_wire_byte(fcs, i);
        end
        tx_buf[n + FCS_LEN - 1] = tx_buf[n + FCS_LEN - 1] ^ fcs_xor[7:0];
        byte_base = rx_byte_count;
        base      = evt_count;
        drive_frame(n + FCS_LEN, err_idx);
        if (exp_len != 0) begin
            waited = 0;
            while (evt_count[1] == base[1] && waited < 32) begin
                @(negedge rx_clk);
                waited++;
            end
            if (evt_count[1] == base[1]) begin
                $display("timeout at %0t ns: no rx_last after the end of the frame", $time);
                timeout_count++;
            end
        end
        idle_gap();  // lets the control frame and pause pulses settle.
        got_len = rx_byte_count - byte_base;
        check_value("rx_valid byte count", got_len, exp_len);
        for (i = 0; i < exp_len && i < got_len; i++) begin
            check_value("rx_data", rx_bytes[(byte_base + i) % BUF_DEPTH], tx_buf[i]);
        end
        if (exp_len != 0 && evt_count[1] != base[1]) begin
            check_value("rx_last position", last_pos - byte_base, exp_len);
        end
        if (exp_len != 0 && evt_count[0] != base[0]) begin
            check_value("rx_start_packet position", start_pos - byte_base, 0);
        end
        exp_evt = {exp_flags[4:0], exp_len != 0, exp_len != 0};
        for (i = 0; i < NUM_EVT; i++) begin
            check_value(evt_name[i], evt_count[i] - base[i], exp_evt[i]);
        end
        check_value("rx_lfc_req", rx_lfc_req, exp_flags[5]);
    endtask

    // hold the ack and count quanta until the request drops.
    task automatic run_pause_wait(input int exp_count);
        int   count;
        int   waited;
        logic done;
        count  = 0;
        waited = 0;
        done   = 1'b0;
        @(negedge rx_clk);
        rx_lfc_ack = 1'b1;
        while (!done && waited < exp_count * QUANTA_CYCLES + 200) begin
            @(negedge rx_clk);
            waited++;
            if (stat_rx_lfc_paused) begin
                count++;
            end
            done = !rx_lfc_req;
        end
        rx_lfc_ack = 1'b0;
        if (!done) begin
            $display("timeout at %0t ns: rx_lfc_req never fell", $time);
            timeout_count++;
        end
        check_value("stat_rx_lfc_paused count", count, exp_count);
        idle_gap();
    endtask

    initial begin
        int   pc;
        logic running;
        gmii_rxd   = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        rx_lfc_ack = 1'b0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        $readmemh("eth_mac_rx_patterns.txt", pat_mem);
        wait_for_reset();
        check_value("rx_valid", rx_valid, 0);
        check_value("rx_last", rx_last, 0);
        check_value("rx_lfc_req", rx_lfc_req, 0);
        check_value("stat_rx_lfc_paused", stat_rx_lfc_paused, 0);
        for (int e = 0; e < NUM_EVT; e++) begin
            check_value(evt_name[e], evt_count[e], 0);  // no pulse during reset.
        end
        idle_gap();
        pc      = 0;
        running = 1'b1;
        while (running && pc < MEM_DEPTH) begin
            case (pat_mem[pc])
                8'h00: running = 1'b0;
                8'h01: begin
                    write_config(pat_mem[pc + 1][2:0], {pat_mem[pc + 2], pat_mem[pc + 3]});
                    pc = pc + 4;
                end
                8'h02: run_frame_step(pc);
                8'h03: begin
                    run_pause_wait({pat_mem[pc + 1], pat_mem[pc + 2]});
                    pc = pc + 3;
                end
                default: begin
                    $display("unknown step code at pattern offset %0d", pc);
                    error_count++;
                    running = 1'b0;
                end
            endcase
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,  // ns.
    parameter int RESET_CYCLES = 5
) (
    output logic rx_clk,
    output logic rx_rst
);
    initial begin
        rx_clk = 1'b0;
        forever #(HALF_PERIOD) rx_clk = ~rx_clk;
    end

    initial begin
        rx_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge rx_clk);
        @(negedge rx_clk);
        rx_rst = 1'b0;  // released away from the rising edge.
    end

endmodule

`default_nettype wire

//--- eth_mac_rx.sv
// ethernet mac receive top
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx #(
    parameter int MIN_FRAME_LEN = 64
) (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire eth_rx_pkg::byte_t     gmii_rxd,
    input  wire logic                  gmii_rx_dv,
    input  wire logic                  gmii_rx_er,
    input  wire logic                  rx_lfc_ack,
    input  wire logic                  cfg_wr,
    input  wire eth_rx_pkg::cfg_addr_t cfg_addr,
    input  wire eth_rx_pkg::cfg_data_t cfg_wdata,
    output wire eth_rx_pkg::byte_t     rx_data,
    output wire logic                  rx_valid,
    output wire logic                  rx_last,
    output wire logic                  rx_user,
    output wire logic                  rx_start_packet,
    output wire logic                  rx_error_bad_frame,
    output wire logic                  rx_error_bad_fcs,
    output wire logic                  stat_rx_mcf,
    output wire logic                  stat_rx_lfc_pkt,
    output wire logic                  stat_rx_lfc_paused,
    output wire logic                  rx_lfc_req
);
    import eth_rx_pkg::*;

    // framer to crc.
    logic      crc_init;
    logic      crc_en;
    byte_t     crc_data;
    logic      crc_ok;

    // parser to pause timer.
    logic      mcf_valid;
    quanta_t   mcf_quanta;

    // configuration.
    logic      cfg_rx_enable;
    logic      cfg_lfc_enable;
    mac_addr_t cfg_mcast_dst;
    eth_type_t cfg_lfc_opcode;

    rx_cfg_regs rx_cfg_regs_inst (.*);

    gmii_rx_framer #(
        .MIN_FRAME_LEN(MIN_FRAME_LEN)
    ) gmii_rx_framer_inst (.*);

    eth_crc32 eth_crc32_inst (.*);

    // control frames are also passed on in the stream.
    mcf_rx_parser mcf_rx_parser_inst (.*);

    lfc_rx_pause lfc_rx_pause_inst (.*);

endmodule

`default_nettype wire

//--- rx_cfg_regs.sv
// receive configuration registers
`timescale 1ns/1ps
`default_nettype none

module rx_cfg_regs (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire logic                  cfg_wr,
    input  wire eth_rx_pkg::cfg_addr_t cfg_addr,
    input  wire eth_rx_pkg::cfg_data_t cfg_wdata,
    output logic                       cfg_rx_enable,
    output logic                       cfg_lfc_enable,
    output eth_rx_pkg::mac_addr_t      cfg_mcast_dst,
    output eth_rx_pkg::eth_type_t      cfg_lfc_opcode
);
    import eth_rx_pkg::*;

    // write only, a write lands in the next cycle.
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            cfg_rx_enable  <= 1'b1;
            cfg_lfc_enable <= 1'b0;
            cfg_mcast_dst  <= 48'h0180_c200_0001;  // 802.3 control multicast.
            cfg_lfc_opcode <= 16'h0001;            // pause.
        end else if (cfg_wr) begin
            case (cfg_addr)
                CFG_ADDR_CTRL: begin
                    cfg_rx_enable  <= cfg_wdata[0];
                    cfg_lfc_enable <= cfg_wdata[1];
                end
                CFG_ADDR_DST0: begin
                    cfg_mcast_dst[47:32] <= cfg_wdata;
                end
                CFG_ADDR_DST1: begin
                    cfg_mcast_dst[31:16] <= cfg_wdata;
                end
                CFG_ADDR_DST2: begin
                    cfg_mcast_dst[15:0] <= cfg_wdata;
                end
                CFG_ADDR_LFC_OPCODE: begin
                    cfg_lfc_opcode <= cfg_wdata;
                end
                default: ;  // unmapped addresses are ignored.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- lfc_rx_pause.sv
// link pause timer
`timescale 1ns/1ps
`default_nettype none

module lfc_rx_pause (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire logic                mcf_valid,
    input  wire eth_rx_pkg::quanta_t mcf_quanta,
    input  wire logic                cfg_lfc_enable,
    input  wire logic                rx_lfc_ack,
    output logic                     rx_lfc_req,
    output logic                     stat_rx_lfc_pkt,
    output logic                     stat_rx_lfc_paused
);
    import eth_rx_pkg::*;

    localparam int SUB_W = $clog2(QUANTA_CYCLES);

    quanta_t          quanta_cnt;  // quanta still to wait.
    logic [SUB_W-1:0] sub_cnt;     // byte clocks within the current quantum.

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt         <= '0;
            sub_cnt            <= '0;
            stat_rx_lfc_pkt    <= 1'b0;
            stat_rx_lfc_paused <= 1'b0;
        end else begin
            stat_rx_lfc_pkt    <= 1'b0;
            stat_rx_lfc_paused <= 1'b0;
            if (mcf_valid && cfg_lfc_enable) begin
                quanta_cnt      <= mcf_quanta;  // a new pause frame restarts the timer.
                sub_cnt         <= '0;
                stat_rx_lfc_pkt <= 1'b1;
            end else if ((quanta_cnt != '0) && rx_lfc_ack) begin
                if (sub_cnt == SUB_W'(QUANTA_CYCLES - 1)) begin
                    sub_cnt            <= '0;
                    quanta_cnt         <= quanta_cnt - 1'b1;
                    stat_rx_lfc_paused <= 1'b1;
                end else begin
                    sub_cnt <= sub_cnt + 1'b1;
                end
            end
        end
    end

    assign rx_lfc_req = (quanta_cnt != '0);

endmodule

`default_nettype wire

//--- mcf_rx_parser.sv
// mac control frame parser
`timescale 1ns/1ps
`default_nettype none

module mcf_rx_parser (
    input  wire logic                  rx_clk,
    input  wire logic                  rx_rst,
    input  wire eth_rx_pkg::byte_t     rx_data,
    input  wire logic                  rx_valid,
    input  wire logic                  rx_last,
    input  wire logic                  rx_user,
    input  wire eth_rx_pkg::mac_addr_t cfg_mcast_dst,
    input  wire eth_rx_pkg::eth_type_t cfg_lfc_opcode,
    output logic                       mcf_valid,
    output eth_rx_pkg::quanta_t        mcf_quanta,
    output logic                       stat_rx_mcf
);
    import eth_rx_pkg::*;

    localparam int HDR_LEN = 18;  // dst, src, type, opcode and quanta.

    logic [4:0] ptr;
    mac_addr_t  dst;
    eth_type_t  eth_type;
    eth_type_t  opcode;
    quanta_t    quanta;
    logic       frame_ok;
    logic       mcf_match;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            ptr <= '0;
        end else if (rx_valid) begin
            if (rx_last) begin
                ptr <= '0;
            end else if (ptr != HDR_LEN) begin
                ptr <= ptr + 1'b1;  // holds once the header is in.
            end
        end
    end

    // fields arrive msb first.
    always_ff @(posedge rx_clk) begin
        if (rx_valid) begin
            if (ptr < 6) begin
                dst <= {dst[39:0], rx_data};
            end
            if (ptr == 12 || ptr == 13) begin
                eth_type <= {eth_type[7:0], rx_data};
            end
            if (ptr == 14 || ptr == 15) begin
                opcode <= {opcode[7:0], rx_data};
            end
            if (ptr == 16 || ptr == 17) begin
                quanta <= {quanta[7:0], rx_data};
            end
        end
    end

    // only a good frame with a complete header counts.
    assign frame_ok  = rx_valid && rx_last && !rx_user && (ptr == HDR_LEN);
    assign mcf_match = (dst == cfg_mcast_dst) && (eth_type == MCF_ETH_TYPE);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            stat_rx_mcf <= 1'b0;
            mcf_valid   <= 1'b0;
        end else begin
            stat_rx_mcf <= frame_ok && mcf_match;
            mcf_valid   <= frame_ok && mcf_match && (opcode == cfg_lfc_opcode);
        end
    end

    assign mcf_quanta = quanta;  // stable until the next frame reaches byte 16.

endmodule

`default_nettype wire

//--- gmii_rx_framer.sv
// gmii receive framer
`timescale 1ns/1ps
`default_nettype none

module gmii_rx_framer #(
    parameter int MIN_FRAME_LEN = 64
) (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,
    input  wire eth_rx_pkg::byte_t gmii_rxd,
    input  wire logic              gmii_rx_dv,
    input  wire logic              gmii_rx_er,
    input  wire logic              cfg_rx_enable,
    input  wire logic              crc_ok,
    output logic                   crc_init,
    output logic                   crc_en,
    output eth_rx_pkg::byte_t      crc_data,
    output eth_rx_pkg::byte_t      rx_data,
    output logic                   rx_valid,
    output logic                   rx_last,
    output logic                   rx_user,
    output logic                   rx_start_packet,
    output logic                   rx_error_bad_frame,
    output logic                   rx_error_bad_fcs
);
    import eth_rx_pkg::*;

    rx_state_t   state;
    byte_t       in_rxd;
    logic        in_dv;
    logic        in_er;
    byte_t       dly [FCS_LEN];
    byte_t       out_data;
    logic        out_vld;
    logic        out_first;
    logic [15:0] len_cnt;     // frame bytes including fcs.
    logic        err_seen;
    logic        push;
    logic        bad_len;

    assign push = (state == PAYLOAD) && in_dv;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            in_dv <= 1'b0;
            in_er <= 1'b0;
            state <= IDLE;
        end else begin
            in_dv <= gmii_rx_dv;
            in_er <= gmii_rx_er;
            case (state)
                IDLE: begin
                    if (in_dv) begin
                        state <= (in_rxd == ETH_PREAMBLE) ? PREAMBLE : DISCARD;
                    end
                end
                PREAMBLE: begin
                    if (!in_dv) begin
                        state <= IDLE;
                    end else if (in_rxd == ETH_SFD) begin
                        state <= cfg_rx_enable ? PAYLOAD : DISCARD;  // enable taken here only.
                    end else if (in_rxd != ETH_PREAMBLE) begin
                        state <= DISCARD;
                    end
                end
                default: begin
                    if (!in_dv) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // a byte is known to be payload once FCS_LEN more bytes follow it.
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            len_cnt   <= '0;
            err_seen  <= 1'b0;
            out_vld   <= 1'b0;
            out_first <= 1'b0;
        end else begin
            out_vld   <= push && (len_cnt >= FCS_LEN);
            out_first <= push && (len_cnt == FCS_LEN);
            if (crc_init) begin
                len_cnt  <= '0;
                err_seen <= 1'b0;
            end else if (push) begin
                if (len_cnt != '1) begin
                    len_cnt <= len_cnt + 1'b1;  // saturates on jumbo frames.
                end
                err_seen <= err_seen | in_er;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        in_rxd <= gmii_rxd;
        if (push) begin
            dly[0] <= in_rxd;
            for (int i = 1; i < FCS_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
            out_data <= dly[FCS_LEN-1];
        end
    end

    assign crc_init = (state == PREAMBLE) && in_dv && (in_rxd == ETH_SFD);
    assign crc_en   = push;
    assign crc_data = in_rxd;

    // end of frame is seen one cycle after the last fcs byte.
    assign bad_len  = (len_cnt < MIN_FRAME_LEN);
    assign rx_data  = out_data;
    assign rx_valid = out_vld;
    assign rx_last  = out_vld && !in_dv;
    assign rx_user  = rx_last && (err_seen || bad_len || !crc_ok);

    assign rx_start_packet    = out_first;
    assign rx_error_bad_frame = rx_last && (err_seen || bad_len);
    assign rx_error_bad_fcs   = rx_last && !crc_ok;

endmodule

`default_nettype wire

//--- eth_crc32.sv
// crc-32 check register
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,
    input  wire logic              crc_init,
    input  wire logic              crc_en,
    input  wire eth_rx_pkg::byte_t crc_data,
    output logic                   crc_ok
);
    import eth_rx_pkg::*;

    crc_t crc_reg;
    crc_t crc_next;
    crc_t crc_rev;

    // fold in one byte, lsb first.
    always_comb begin
        crc_next = crc_reg;
        for (int i = 0; i < 8; i++) begin
            crc_next = (crc_next >> 1) ^ (CRC_POLY & {32{crc_next[0] ^ crc_data[i]}});
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_reg <= '1;
        end else if (crc_init) begin
            crc_reg <= '1;  // preset at the sfd.
        end else if (crc_en) begin
            crc_reg <= crc_next;
        end
    end

    // register runs reflected, the residue is written msb first.
    assign crc_rev = {<<{crc_reg}};
    assign crc_ok  = (crc_rev == CRC_RESIDUE);

endmodule

`default_nettype wire

//--- eth_rx_pkg.sv
// ethernet receive definitions
`default_nettype none

package eth_rx_pkg;

    typedef logic [7:0]  byte_t;        // gmii or stream byte.
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;    // ethertype or control opcode.
    typedef logic [15:0] quanta_t;
    typedef logic [31:0] crc_t;
    typedef logic [2:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // framer states.
    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        PAYLOAD,
        DISCARD
    } rx_state_t;

    localparam byte_t     ETH_PREAMBLE  = 8'h55;
    localparam byte_t     ETH_SFD       = 8'hd5;
    localparam crc_t      CRC_POLY      = 32'hedb88320;  // reflected form.
    localparam crc_t      CRC_RESIDUE   = 32'hc704dd7b;
    localparam eth_type_t MCF_ETH_TYPE  = 16'h8808;
    localparam int        FCS_LEN       = 4;
    localparam int        QUANTA_CYCLES = 64;            // 512 bit times, one byte per clock.

    // register map.
    localparam cfg_addr_t CFG_ADDR_CTRL       = 3'd0;
    localparam cfg_addr_t CFG_ADDR_DST0       = 3'd1;  // first two bytes on the wire.
    localparam cfg_addr_t CFG_ADDR_DST1       = 3'd2;
    localparam cfg_addr_t CFG_ADDR_DST2       = 3'd3;
    localparam cfg_addr_t CFG_ADDR_LFC_OPCODE = 3'd4;

endpackage

`default_nettype wire
